// File: hdl/u2_ctrl_defines.svh
////////////////////
// Widths and addresses shared by the control core
// Setting and readback addresses are fixed at build time
////////////////////
`ifndef U2_CTRL_DEFINES_SVH
`define U2_CTRL_DEFINES_SVH

// Bus widths
`define U2_SET_AW        8
`define U2_DW            32
`define U2_RB_AW         4
`define U2_PAGE_BITS     10

// Setting register addresses
`define U2_SR_CLK        8'd0
`define U2_SR_SERDES     8'd1
`define U2_SR_ADC        8'd2
`define U2_SR_LED        8'd3
`define U2_SR_PHY        8'd4
`define U2_SR_PAGE       8'd6
`define U2_SR_ICACHE     8'd7
`define U2_SR_LED_SRC    8'd8

// Readback word addresses
// Words 0 to 7 have no source and read zero
`define U2_RB_STATUS     4'd8
`define U2_RB_MISC       4'd9
`define U2_RB_IRQ        4'd13
`define U2_RB_STATUS_ENC 4'd14
`define U2_RB_CYCLES     4'd15

`endif

// File: hdl/u2_ctrl_pkg.sv
////////////////////
// Types for decoding setting words
// One word is seen as raw data, control flags or a page field
////////////////////
`include "u2_ctrl_defines.svh"

package u2_ctrl_pkg;

   // Flags sit in the low byte
   typedef struct packed {
      logic [`U2_DW-6:0] unused;
      logic [4:0]        flags;
   } ctrl_view_t;

   // Page number is the upper half of a 20-bit page address
   typedef struct packed {
      logic [`U2_DW-2*`U2_PAGE_BITS-1:0] unused;
      logic [`U2_PAGE_BITS-1:0]          ram_page;
      logic [`U2_PAGE_BITS-1:0]          offset;
   } page_view_t;

   typedef union packed {
      logic [`U2_DW-1:0] raw;
      ctrl_view_t        ctrl;
      page_view_t        page;
   } set_word_u;

   // Encoder result with no status bit set
   parameter logic [`U2_DW-1:0] NO_STATUS = '1;

endpackage

// File: hdl/ctrl_word_if.sv
////////////////////
// Register values from the setting bank to the line driver
// Plain levels with no handshake
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

interface ctrl_word_if;

   logic [4:0]               clock_word;
   logic [3:0]               serdes_word;
   logic [3:0]               adc_word;
   logic [7:0]               led_sw;
   logic [7:0]               led_src;
   logic                     phy_reset;
   logic [`U2_PAGE_BITS-1:0] ram_page;

   modport bank (output clock_word, serdes_word, adc_word, led_sw, led_src,
                 phy_reset, ram_page);
   modport driver (input clock_word, serdes_word, adc_word, led_sw, led_src,
                   phy_reset, ram_page);

endinterface

// File: hdl/setting_bank.sv
////////////////////
// Setting register bank
// Writes to unmapped addresses are dropped
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module setting_bank (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  logic                  set_stb_i,
   input  logic [`U2_SET_AW-1:0] set_addr_i,
   input  logic [`U2_DW-1:0]     set_data_i,
   output logic                  flush_icache_o,
   ctrl_word_if.bank             cw
);

   u2_ctrl_pkg::set_word_u set_word;

   assign set_word = set_data_i;

   ////////////////////
   // Register loads
   ////////////////////
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cw.clock_word  <= '0;
         cw.serdes_word <= '0;
         cw.adc_word    <= '0;
         cw.led_sw      <= '0;
         cw.led_src     <= '0;
         cw.phy_reset   <= 1'b0;
         cw.ram_page    <= '0;
      end else if (set_stb_i) begin
         case (set_addr_i)
            `U2_SR_CLK:     cw.clock_word  <= set_word.ctrl.flags;
            `U2_SR_SERDES:  cw.serdes_word <= set_word.ctrl.flags[3:0];
            `U2_SR_ADC:     cw.adc_word    <= set_word.ctrl.flags[3:0];
            `U2_SR_PHY:     cw.phy_reset   <= set_word.ctrl.flags[0];
            // LED words take the low byte as is
            `U2_SR_LED:     cw.led_sw      <= set_word.raw[7:0];
            `U2_SR_LED_SRC: cw.led_src     <= set_word.raw[7:0];
            `U2_SR_PAGE:    cw.ram_page    <= set_word.page.ram_page;
            default: ;
         endcase
      end
   end

   ////////////////////
   // Icache flush
   ////////////////////
   // Only the write itself counts and the data is ignored
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         flush_icache_o <= 1'b0;
      end else begin
         flush_icache_o <= set_stb_i && (set_addr_i == `U2_SR_ICACHE);
      end
   end

endmodule

// File: hdl/ctrl_line_driver.sv
////////////////////
// Registered control pins and LED mux
// Pins lag the setting registers by one cycle
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module ctrl_line_driver (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   ctrl_word_if.driver              cw,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_reset_n_o,
   output logic [7:0]               leds_o,
   output logic [`U2_PAGE_BITS-1:0] ram_page_o
);

   logic [7:0] led_hw;

   // Hardware status on the two low LEDs
   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         {clock_ready_o, clk_en_o, clk_sel_o} <= '0;
         {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} <= '0;
         {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} <= '0;
         phy_reset_n_o <= 1'b1;
         leds_o        <= '0;
         ram_page_o    <= '0;
      end else begin
         {clock_ready_o, clk_en_o, clk_sel_o} <= cw.clock_word;
         {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} <= cw.serdes_word;
         {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} <= cw.adc_word;
         // PHY reset pin is active low
         phy_reset_n_o <= ~cw.phy_reset;
         // Source bit 1 selects hardware
         leds_o        <= (cw.led_src & led_hw) | (~cw.led_src & cw.led_sw);
         ram_page_o    <= cw.ram_page;
      end
   end

endmodule

// File: hdl/status_encoder.sv
////////////////////
// Status and interrupt words plus cycle counter
// Status words lag their inputs by one cycle
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module status_encoder (
   input  logic              dsp_clk,
   input  logic              wb_rst,
   input  logic [`U2_DW-1:0] status_i,
   input  logic [7:0]        irq_src_i,
   input  logic              uart_tx_int_i,
   input  logic              uart_rx_int_i,
   input  logic              clk_status_i,
   input  logic              serdes_link_up_i,
   input  logic              sim_mode_i,
   input  logic [3:0]        clock_divider_i,
   output logic [`U2_DW-1:0] status_o,
   output logic [`U2_DW-1:0] irq_o,
   output logic [`U2_DW-1:0] status_enc_o,
   output logic [`U2_DW-1:0] misc_o,
   output logic [`U2_DW-1:0] cycles_o
);

   logic [`U2_DW-1:0] enc;

   ////////////////////
   // Priority encoder
   ////////////////////
   // Highest set bit of the low half wins
   always_comb begin
      enc = u2_ctrl_pkg::NO_STATUS;
      for (int i = 0; i < 16; i++) begin
         if (status_i[i]) begin
            enc = i;
         end
      end
   end

   // Registered status words
   always_ff @(posedge dsp_clk) begin
      status_o     <= status_i;
      status_enc_o <= enc;
      irq_o        <= {20'b0, clk_status_i, serdes_link_up_i,
                       uart_tx_int_i, uart_rx_int_i, irq_src_i};
      misc_o       <= {sim_mode_i, 27'b0, clock_divider_i};
   end

   // Free running cycle count
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycles_o <= '0;
      end else begin
         cycles_o <= cycles_o + 32'd1;
      end
   end

endmodule

// File: hdl/status_readback.sv
////////////////////
// 16-word readback with single-cycle acknowledge
// No back-pressure and words 0 to 7 read zero
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module status_readback (
   input  logic                 dsp_clk,
   input  logic                 wb_rst,
   input  logic                 rb_stb_i,
   input  logic [`U2_RB_AW-1:0] rb_addr_i,
   input  logic [`U2_DW-1:0]    status_i,
   input  logic [`U2_DW-1:0]    irq_i,
   input  logic [`U2_DW-1:0]    status_enc_i,
   input  logic [`U2_DW-1:0]    misc_i,
   input  logic [`U2_DW-1:0]    cycles_i,
   output logic                 rb_ack_o,
   output logic [`U2_DW-1:0]    rb_data_o
);

   logic [`U2_DW-1:0] word;

   always_comb begin
      case (rb_addr_i)
         `U2_RB_STATUS:     word = status_i;
         `U2_RB_MISC:       word = misc_i;
         `U2_RB_IRQ:        word = irq_i;
         `U2_RB_STATUS_ENC: word = status_enc_i;
         `U2_RB_CYCLES:     word = cycles_i;
         default:           word = '0;
      endcase
   end

   // Data captured with the strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= word;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

endmodule

// File: hdl/u2_ctrl_core.sv
////////////////////
// Control and status plane on dsp_clk
// Strobes are single cycle with no back-pressure
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module u2_ctrl_core (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   // Settings bus
   input  logic                     set_stb_i,
   input  logic [`U2_SET_AW-1:0]    set_addr_i,
   input  logic [`U2_DW-1:0]        set_data_i,
   // Readback
   input  logic                     rb_stb_i,
   input  logic [`U2_RB_AW-1:0]     rb_addr_i,
   output logic                     rb_ack_o,
   output logic [`U2_DW-1:0]        rb_data_o,
   // Status sources
   input  logic [`U2_DW-1:0]        status_i,
   input  logic [7:0]               irq_src_i,
   input  logic                     uart_tx_int_i,
   input  logic                     uart_rx_int_i,
   input  logic                     clk_status_i,
   input  logic                     serdes_link_up_i,
   input  logic                     sim_mode_i,
   input  logic [3:0]               clock_divider_i,
   // Control pins
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_reset_n_o,
   output logic [7:0]               leds_o,
   output logic [`U2_PAGE_BITS-1:0] ram_page_o,
   output logic                     flush_icache_o
);

   logic [`U2_DW-1:0] status_w;
   logic [`U2_DW-1:0] irq_w;
   logic [`U2_DW-1:0] status_enc_w;
   logic [`U2_DW-1:0] misc_w;
   logic [`U2_DW-1:0] cycles_w;

   ctrl_word_if i_cw ();

   ////////////////////
   // Control branch
   ////////////////////
   setting_bank i_setting_bank (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .flush_icache_o(flush_icache_o), .cw(i_cw.bank));

   ctrl_line_driver i_ctrl_line_driver (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .cw(i_cw.driver),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o), .ram_page_o(ram_page_o));

   ////////////////////
   // Status branch
   ////////////////////
   status_encoder i_status_encoder (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .status_i(status_i),
      .irq_src_i(irq_src_i), .uart_tx_int_i(uart_tx_int_i),
      .uart_rx_int_i(uart_rx_int_i), .clk_status_i(clk_status_i),
      .serdes_link_up_i(serdes_link_up_i), .sim_mode_i(sim_mode_i),
      .clock_divider_i(clock_divider_i), .status_o(status_w), .irq_o(irq_w),
      .status_enc_o(status_enc_w), .misc_o(misc_w), .cycles_o(cycles_w));

   status_readback i_status_readback (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .rb_stb_i(rb_stb_i),
      .rb_addr_i(rb_addr_i), .status_i(status_w), .irq_i(irq_w),
      .status_enc_i(status_enc_w), .misc_i(misc_w), .cycles_i(cycles_w),
      .rb_ack_o(rb_ack_o), .rb_data_o(rb_data_o));

endmodule

// File: bench/u2_ctrl_core_chk.sv
////////////////////
// Protocol checks bound to the control core top level
// Reset checks assume pins settle on the first reset edge
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module u2_ctrl_core_chk (
   input logic                  dsp_clk,
   input logic                  wb_rst,
   input logic                  set_stb_i,
   input logic [`U2_SET_AW-1:0] set_addr_i,
   input logic                  rb_stb_i,
   input logic                  rb_ack_o,
   input logic                  flush_icache_o,
   input logic                  clock_ready_o,
   input logic [1:0]            clk_en_o,
   input logic [1:0]            clk_sel_o,
   input logic                  ser_enable_o,
   input logic                  ser_prbsen_o,
   input logic                  ser_loopen_o,
   input logic                  ser_rx_en_o,
   input logic                  adc_oe_a_o,
   input logic                  adc_on_a_o,
   input logic                  adc_oe_b_o,
   input logic                  adc_on_b_o,
   input logic                  phy_reset_n_o,
   input logic [7:0]            leds_o,
   input logic [9:0]            ram_page_o
);

   logic [30:0] pins;

   // Number of failed assertions
   int assert_errors = 0;

   assign pins = {clock_ready_o, clk_en_o, clk_sel_o, ser_enable_o, ser_prbsen_o,
                  ser_loopen_o, ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o,
                  adc_on_b_o, leds_o, ram_page_o};

   ////////////////////
   // Readback handshake
   ////////////////////
   a_ack_after_stb: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      rb_stb_i |=> rb_ack_o)
      else begin
         $error("Read strobe not acknowledged in the next cycle");
         assert_errors++;
      end

   a_ack_needs_stb: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      rb_ack_o |-> $past(rb_stb_i))
      else begin
         $error("Acknowledge without a read strobe");
         assert_errors++;
      end

   // Flush only follows an icache write
   a_flush_after_write: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      flush_icache_o |-> $past(set_stb_i && (set_addr_i == `U2_SR_ICACHE)))
      else begin
         $error("Flush pulse without an icache write");
         assert_errors++;
      end

   a_reset_pins: assert property (@(posedge dsp_clk)
      wb_rst |=> (pins == '0 && phy_reset_n_o && !flush_icache_o && !rb_ack_o))
      else begin
         $error("Pins left their reset values during reset");
         assert_errors++;
      end

endmodule

// File: bench/u2_ctrl_core_tb.sv
////////////////////
// Random test of the control core against a shadow model
// Seed is fixed, so every run repeats the same stimulus
////////////////////
`timescale 1ns/1ps
`include "u2_ctrl_defines.svh"

module u2_ctrl_core_tb;

   // Run limit well above the length of all tests
   localparam int TIMEOUT_CYCLES = 5000;

   logic        dsp_clk;
   logic        wb_rst;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic        rb_stb_i;
   logic [3:0]  rb_addr_i;
   logic        rb_ack_o;
   logic [31:0] rb_data_o;
   logic [31:0] status_i;
   logic [7:0]  irq_src_i;
   logic        uart_tx_int_i;
   logic        uart_rx_int_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic        sim_mode_i;
   logic [3:0]  clock_divider_i;
   logic        clock_ready_o;
   logic [1:0]  clk_en_o;
   logic [1:0]  clk_sel_o;
   logic        ser_enable_o;
   logic        ser_prbsen_o;
   logic        ser_loopen_o;
   logic        ser_rx_en_o;
   logic        adc_oe_a_o;
   logic        adc_on_a_o;
   logic        adc_oe_b_o;
   logic        adc_on_b_o;
   logic        phy_reset_n_o;
   logic [7:0]  leds_o;
   logic [9:0]  ram_page_o;
   logic        flush_icache_o;

   // Shadow of the setting registers
   logic [4:0]  sh_clock;
   logic [3:0]  sh_serdes;
   logic [3:0]  sh_adc;
   logic [7:0]  sh_led_sw;
   logic [7:0]  sh_led_src;
   logic        sh_phy;
   logic [9:0]  sh_page;

   logic [31:0] rng_state = 32'd65667;
   int          cycle_count = 0;
   int          rel_cycle = 0;
   int          test_errors = 0;
   int          total_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   string       test_name;

   u2_ctrl_core i_u2_ctrl_core (.*);

   bind u2_ctrl_core u2_ctrl_core_chk i_u2_ctrl_core_chk (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin : watchdog
      wait (cycle_count >= TIMEOUT_CYCLES);
      $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   ////////////////////
   // Model
   ////////////////////
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Hardware status only on LED bits 1 and 0
   function automatic logic [7:0] expected_leds();
      logic [7:0] hw;
      logic [7:0] leds;
      hw = 8'h00;
      hw[1] = clk_status_i;
      hw[0] = serdes_link_up_i;
      for (int i = 0; i < 8; i++) begin
         leds[i] = sh_led_src[i] ? hw[i] : sh_led_sw[i];
      end
      return leds;
   endfunction

   function automatic logic [31:0] expected_word(logic [3:0] addr, int stb_cycle);
      logic [31:0] w;
      w = 32'h0;
      case (addr)
         `U2_RB_STATUS: w = status_i;
         `U2_RB_MISC: begin
            w[31]  = sim_mode_i;
            w[3:0] = clock_divider_i;
         end
         `U2_RB_IRQ: begin
            w[7:0] = irq_src_i;
            w[8]   = uart_rx_int_i;
            w[9]   = uart_tx_int_i;
            w[10]  = serdes_link_up_i;
            w[11]  = clk_status_i;
         end
         `U2_RB_STATUS_ENC: begin
            // All ones when no status bit is set
            w = 32'hffff_ffff;
            for (int i = 15; i >= 0; i--) begin
               if (status_i[i]) begin
                  w = 32'(i);
                  break;
               end
            end
         end
         // Count runs from the first edge out of reset
         `U2_RB_CYCLES: w = 32'(stb_cycle - rel_cycle);
         default: w = 32'h0;
      endcase
      return w;
   endfunction

   ////////////////////
   // Checks and bus tasks
   ////////////////////
   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %s %s expected 0x%08h actual 0x%08h",
                  test_name, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("Test %s: %s", test_name, msg);
      test_errors++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("Test %s passed", test_name);
      end else begin
         tests_failed++;
         $display("Test %s failed with %0d errors", test_name, test_errors);
      end
   endtask

   // Pins trail the registers by one edge
   task automatic check_pins();
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_value("clock pins", 32'(sh_clock), 32'({clock_ready_o, clk_en_o, clk_sel_o}));
      check_value("serdes pins", 32'(sh_serdes),
                  32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}));
      check_value("adc pins", 32'(sh_adc),
                  32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}));
      check_value("phy_reset_n", 32'(!sh_phy), 32'(phy_reset_n_o));
      check_value("leds", 32'(expected_leds()), 32'(leds_o));
      check_value("ram_page", 32'(sh_page), 32'(ram_page_o));
      check_value("flush", 32'h0, 32'(flush_icache_o));
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
      case (addr)
         `U2_SR_CLK:     sh_clock   = data[4:0];
         `U2_SR_SERDES:  sh_serdes  = data[3:0];
         `U2_SR_ADC:     sh_adc     = data[3:0];
         `U2_SR_LED:     sh_led_sw  = data[7:0];
         `U2_SR_PHY:     sh_phy     = data[0];
         `U2_SR_PAGE:    sh_page    = data[19:10];
         `U2_SR_LED_SRC: sh_led_src = data[7:0];
         default: ;
      endcase
   endtask

   task automatic read_word(input logic [3:0] addr, output logic [31:0] data,
                            output int stb_cycle);
      int waited;
      waited = 0;
      @(posedge dsp_clk);
      rb_stb_i  <= 1'b1;
      rb_addr_i <= addr;
      stb_cycle = cycle_count;
      @(posedge dsp_clk);
      rb_stb_i  <= 1'b0;
      @(negedge dsp_clk);
      while (!rb_ack_o && waited < 8) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (!rb_ack_o) begin
         report_failure($sformatf("no acknowledge for read of word %0d", addr));
      end else if (waited != 0) begin
         report_failure($sformatf("acknowledge for word %0d came %0d cycles late",
                                  addr, waited));
      end
      data = rb_data_o;
   endtask

   task automatic read_and_check(input logic [3:0] addr);
      logic [31:0] data;
      int          stb_cycle;
      read_word(addr, data, stb_cycle);
      check_value($sformatf("word %0d", addr), expected_word(addr, stb_cycle), data);
   endtask

   // Mode 0 clears status and mode 1 sets only the upper half
   task automatic drive_random_status(input int mode);
      logic [31:0] r;
      logic [31:0] s;
      r = next_random();
      s = next_random();
      @(posedge dsp_clk);
      case (mode)
         0: status_i <= 32'h0;
         1: status_i <= r & 32'hffff_0000;
         default: status_i <= r >> s[4:0];
      endcase
      irq_src_i        <= s[15:8];
      uart_tx_int_i    <= s[16];
      uart_rx_int_i    <= s[17];
      clk_status_i     <= s[18];
      serdes_link_up_i <= s[19];
      sim_mode_i       <= s[20];
      clock_divider_i  <= s[24:21];
      repeat (3) @(posedge dsp_clk);
   endtask

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin : main
      logic [31:0] r;
      logic [31:0] c1;
      logic [31:0] c2;
      logic [7:0]  addr;
      logic [3:0]  rb_addrs [8];
      int          rb_cycles [8];
      int          s1;
      int          s2;
      int          gap;
      int          pulses;
      int          assert_fails;
      wb_rst           = 1'b1;
      set_stb_i        = 1'b0;
      set_addr_i       = 8'h0;
      set_data_i       = 32'h0;
      rb_stb_i         = 1'b0;
      rb_addr_i        = 4'h0;
      status_i         = 32'h0;
      irq_src_i        = 8'h0;
      uart_tx_int_i    = 1'b0;
      uart_rx_int_i    = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      sim_mode_i       = 1'b0;
      clock_divider_i  = 4'h0;
      {sh_clock, sh_serdes, sh_adc, sh_led_sw, sh_led_src, sh_phy, sh_page} = '0;
      repeat (8) @(posedge dsp_clk);
      wb_rst <= 1'b0;
      rel_cycle = cycle_count;

      start_test("reset");
      check_pins();
      check_value("rb_ack", 32'h0, 32'(rb_ack_o));
      read_and_check(`U2_RB_CYCLES);
      finish_test();

      start_test("control_pins");
      for (int i = 0; i < 25; i++) begin
         r = next_random();
         case (i % 5)
            0: addr = `U2_SR_CLK;
            1: addr = `U2_SR_SERDES;
            2: addr = `U2_SR_ADC;
            3: addr = `U2_SR_PHY;
            default: addr = (r[7:0] < 8'd9) ? 8'd5 : r[7:0];
         endcase
         write_setting(addr, next_random());
         check_pins();
      end
      finish_test();

      start_test("leds_page_flush");
      for (int i = 0; i < 12; i++) begin
         r = next_random();
         @(posedge dsp_clk);
         clk_status_i     <= r[0];
         serdes_link_up_i <= r[1];
         write_setting(`U2_SR_LED, next_random());
         write_setting(`U2_SR_LED_SRC, next_random());
         write_setting(`U2_SR_PAGE, next_random());
         check_pins();
      end
      write_setting(`U2_SR_ICACHE, next_random());
      pulses = 0;
      repeat (4) begin
         @(negedge dsp_clk);
         if (flush_icache_o) begin
            pulses++;
         end
      end
      check_value("flush pulses", 32'd1, 32'(pulses));
      check_pins();
      finish_test();

      start_test("status_words");
      for (int i = 0; i < 10; i++) begin
         drive_random_status(i);
         read_and_check(`U2_RB_STATUS);
         read_and_check(`U2_RB_IRQ);
         read_and_check(`U2_RB_MISC);
         read_and_check(`U2_RB_STATUS_ENC);
      end
      for (int a = 0; a < 8; a++) begin
         read_and_check(4'(a));
      end
      finish_test();

      start_test("cycle_counter");
      for (int i = 0; i < 6; i++) begin
         read_word(`U2_RB_CYCLES, c1, s1);
         gap = 1 + int'(next_random() % 32'd40);
         repeat (gap) @(posedge dsp_clk);
         read_word(`U2_RB_CYCLES, c2, s2);
         check_value("cycle difference", 32'(s2 - s1), c2 - c1);
      end
      finish_test();

      start_test("back_to_back");
      drive_random_status(2);
      for (int i = 0; i < 8; i++) begin
         r = next_random();
         rb_addrs[i] = (i % 2 == 0) ? r[3:0] : {1'b1, r[2:0]};
      end
      // Acknowledge for strobe i shows after the edge of strobe i + 1
      for (int i = 0; i <= 8; i++) begin
         @(posedge dsp_clk);
         if (i < 8) begin
            rb_stb_i     <= 1'b1;
            rb_addr_i    <= rb_addrs[i];
            rb_cycles[i] = cycle_count;
         end else begin
            rb_stb_i <= 1'b0;
         end
         @(negedge dsp_clk);
         if (i > 0) begin
            if (!rb_ack_o) begin
               report_failure($sformatf("missing acknowledge for read %0d", i - 1));
            end
            check_value($sformatf("word %0d", rb_addrs[i - 1]),
                        expected_word(rb_addrs[i - 1], rb_cycles[i - 1]), rb_data_o);
         end
      end
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_value("rb_ack after burst", 32'h0, 32'(rb_ack_o));
      finish_test();

      assert_fails = i_u2_ctrl_core.i_u2_ctrl_core_chk.assert_errors;
      $display("Tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
               tests_run, tests_failed, total_errors, assert_fails);
      if (tests_failed == 0 && assert_fails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: u2_ctrl_core.f
+incdir+hdl
hdl/u2_ctrl_pkg.sv
hdl/ctrl_word_if.sv
hdl/setting_bank.sv
hdl/ctrl_line_driver.sv
hdl/status_encoder.sv
hdl/status_readback.sv
hdl/u2_ctrl_core.sv
bench/u2_ctrl_core_chk.sv
bench/u2_ctrl_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the control core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module u2_ctrl_core_tb -f u2_ctrl_core.f; then
   echo "Verilator build failed"
   exit 1
fi

if ! sim_out=$(./obj_dir/Vu2_ctrl_core_tb 2>&1); then
   printf '%s\n' "$sim_out"
   echo "Simulation exited with an error"
   exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "^ALL TESTS PASSED$"; then
   exit 0
fi
echo "Pass message not found"
exit 1
